//--- logic/dma_endpoint_pkg.sv
package dma_endpoint_pkg;

    // Register file geometry
    localparam int DATAPATH_WIDTH = 20;
    localparam int REGISTER_FILE_DEPTH = 64;
    localparam int CHANNEL_COUNT = 16;
    localparam int REG_ADDR_WIDTH = $clog2(CHANNEL_COUNT * REGISTER_FILE_DEPTH);
    localparam int IO_ADDR_WIDTH = $clog2(REGISTER_FILE_DEPTH);

    typedef struct packed {
        logic [15:0] channel;
        logic [15:0] io_address;
        logic [DATAPATH_WIDTH-1:0] data;
    } stream_write_t;

    typedef struct packed {
        logic [15:0] channel;
        logic [15:0] io_address;
    } stream_read_req_t;

    typedef struct packed {
        logic [15:0] io_address;
        logic [31:0] reg_index;
    } table_entry_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] address;
        logic [DATAPATH_WIDTH-1:0] data;
    } reg_write_t;

    // Index is the word offset from the bus base address
    typedef struct packed {
        logic [15:0] index;
        logic [31:0] data;
    } bus_txn_t;

    typedef struct packed {
        logic [15:0] program_size;
        logic [15:0] channel_count;
    } config_t;

    typedef enum logic [1:0] {
        idle,
        bus_read,
        wait_read,
        stream_read
    } read_state_e;

    typedef enum logic {
        init_transparent,
        init_zero
    } table_init_e;

endpackage

//--- logic/bus_register_decoder.sv
`timescale 1ns/1ps

module bus_register_decoder import dma_endpoint_pkg::*; #(
    parameter logic [31:0] BASE_ADDRESS = 32'h43c0_0000
)(
    input  logic        clock,
    input  logic        reset,
    input  logic        bus_write,
    input  logic        bus_read,
    input  logic [31:0] bus_address,
    input  logic [31:0] bus_write_data,
    input  logic        response_valid,
    input  logic [31:0] response_data,
    output logic        write_valid,
    output bus_txn_t    write_txn,
    output logic        read_valid,
    output bus_txn_t    read_txn,
    output logic        bus_read_valid,
    output logic [31:0] bus_read_data
);

    // Size of the register window above the base, in bytes
    localparam logic [31:0] WINDOW_BYTES = 32'h0000_1000;

    logic [31:0] byte_offset;
    logic        in_window;
    bus_txn_t    decoded;

    assign byte_offset = bus_address - BASE_ADDRESS;
    assign in_window = (bus_address >= BASE_ADDRESS) && (byte_offset < WINDOW_BYTES);

    // Byte address to word index, the window holds 1024 words
    always_comb begin
        decoded.index = {6'b0, byte_offset[11:2]};
        decoded.data = bus_write_data;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_valid <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            write_valid <= bus_write && in_window;
            read_valid <= bus_read && in_window;
        end
    end

    always_ff @(posedge clock) begin
        if (bus_write) begin
            write_txn <= decoded;
        end
        // Reads carry only the index
        if (bus_read) begin
            read_txn <= '{index: decoded.index, data: 32'b0};
        end
    end

    // The response comes straight from the endpoint
    assign bus_read_valid = response_valid;
    assign bus_read_data = response_data;

endmodule

//--- logic/io_translation_table.sv
`timescale 1ns/1ps

module io_translation_table import dma_endpoint_pkg::*; #(
    parameter table_init_e TABLE_INIT = init_transparent
)(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     entry_write_valid,
    input  table_entry_t             entry_write,
    input  logic [IO_ADDR_WIDTH-1:0] write_lookup_address,
    input  logic [IO_ADDR_WIDTH-1:0] read_lookup_address,
    output logic [31:0]              write_lookup_entry,
    output logic [31:0]              read_lookup_entry
);

    // One entry per IO address, zero marks the address as unmapped
    logic [31:0] entries [REGISTER_FILE_DEPTH];

    logic [IO_ADDR_WIDTH-1:0] entry_index;

    assign entry_index = entry_write.io_address[IO_ADDR_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < REGISTER_FILE_DEPTH; i++) begin
                if (TABLE_INIT == init_transparent) begin
                    entries[i] <= 32'(i);
                end else begin
                    entries[i] <= 32'b0;
                end
            end
        end else if (entry_write_valid) begin
            entries[entry_index] <= entry_write.reg_index;
        end
    end

    // Separate lookups so a write and a read can translate in the same cycle
    assign write_lookup_entry = entries[write_lookup_address];
    assign read_lookup_entry = entries[read_lookup_address];

endmodule

//--- logic/dma_endpoint.sv
`timescale 1ns/1ps

module dma_endpoint import dma_endpoint_pkg::*; #(
    parameter int RAW_BUS_ACCESS = 1
)(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      stream_write_valid,
    input  stream_write_t             stream_write,
    input  logic                      bus_write_valid,
    input  bus_txn_t                  bus_write_txn,
    input  logic                      bus_read_valid,
    input  bus_txn_t                  bus_read_txn,
    input  logic                      read_request_valid,
    input  stream_read_req_t          read_request,
    input  logic [31:0]               write_lookup_entry,
    input  logic [31:0]               read_lookup_entry,
    input  logic [DATAPATH_WIDTH-1:0] dma_read_data,
    output logic [IO_ADDR_WIDTH-1:0]  write_lookup_address,
    output logic [IO_ADDR_WIDTH-1:0]  read_lookup_address,
    output logic                      reg_write_valid,
    output reg_write_t                reg_write,
    output logic [REG_ADDR_WIDTH-1:0] dma_read_address,
    output logic                      read_request_ready,
    output logic                      read_response_valid,
    output logic [DATAPATH_WIDTH-1:0] read_response_data,
    output logic                      bus_response_valid,
    output logic [31:0]               bus_response_data,
    output config_t                   active_config
);

    // Bank base plus translated entry, cut to the flat register address
    function automatic logic [REG_ADDR_WIDTH-1:0] flat_address(
        input logic [15:0] channel,
        input logic [31:0] entry
    );
        logic [31:0] flat;
        flat = 32'(channel) * 32'(REGISTER_FILE_DEPTH) + entry;
        return flat[REG_ADDR_WIDTH-1:0];
    endfunction

    logic        write_hit;
    logic        config_write;
    reg_write_t  write_target;
    read_state_e state;
    logic        read_config;
    logic        stream_accept;
    logic        start_read;
    logic [REG_ADDR_WIDTH-1:0] next_read_address;

    // Write side: the stream wins, a bus write in the same cycle is lost
    assign write_lookup_address = stream_write_valid ?
        stream_write.io_address[IO_ADDR_WIDTH-1:0] : bus_write_txn.index[IO_ADDR_WIDTH-1:0];

    always_comb begin
        write_hit = 1'b0;
        config_write = 1'b0;
        write_target = '0;
        if (stream_write_valid) begin
            write_target.address = flat_address(stream_write.channel, write_lookup_entry);
            write_target.data = stream_write.data;
            write_hit = write_lookup_entry != 32'b0;
        end else if (bus_write_valid) begin
            if (bus_write_txn.index == 16'b0) begin
                config_write = 1'b1;
            end else begin
                write_target.data = bus_write_txn.data[DATAPATH_WIDTH-1:0];
                if (RAW_BUS_ACCESS != 0) begin
                    write_target.address = bus_write_txn.index[REG_ADDR_WIDTH-1:0];
                    write_hit = 1'b1;
                end else begin
                    // Translated bus writes always go to bank 0
                    write_target.address = flat_address(16'b0, write_lookup_entry);
                    write_hit = write_lookup_entry != 32'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            reg_write_valid <= 1'b0;
            active_config <= '0;
        end else begin
            reg_write_valid <= write_hit;
            if (config_write) begin
                active_config <= config_t'(bus_write_txn.data);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_hit) begin
            reg_write <= write_target;
        end
    end

    // Read side: a stream request takes precedence over a bus read
    assign stream_accept = read_request_valid && read_request_ready;
    assign start_read = (state == idle) && (stream_accept || bus_read_valid);

    assign read_lookup_address = read_request_valid ?
        read_request.io_address[IO_ADDR_WIDTH-1:0] : bus_read_txn.index[IO_ADDR_WIDTH-1:0];

    assign next_read_address = stream_accept ?
        flat_address(read_request.channel, read_lookup_entry) :
        flat_address(16'b0, read_lookup_entry);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            read_request_ready <= 1'b1;
            read_response_valid <= 1'b0;
            read_config <= 1'b0;
        end else begin
            read_response_valid <= 1'b0;
            case (state)
                idle: begin
                    if (stream_accept) begin
                        read_request_ready <= 1'b0;
                        state <= wait_read;
                    end else if (bus_read_valid) begin
                        read_config <= bus_read_txn.index == 16'b0;
                        read_request_ready <= 1'b0;
                        state <= bus_read;
                    end
                end
                wait_read: begin
                    state <= stream_read;
                end
                stream_read: begin
                    read_response_valid <= 1'b1;
                    read_request_ready <= 1'b1;
                    state <= idle;
                end
                bus_read: begin
                    read_config <= 1'b0;
                    read_request_ready <= 1'b1;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start_read) begin
            dma_read_address <= next_read_address;
        end
        if (state == stream_read) begin
            read_response_data <= dma_read_data;
        end
    end

    // Bus data is served in the cycle the FSM sits in bus_read
    always_comb begin
        bus_response_valid = state == bus_read;
        bus_response_data = 32'b0;
        if (state == bus_read) begin
            if (read_config) begin
                bus_response_data = active_config;
            end else begin
                bus_response_data = {{(32 - DATAPATH_WIDTH){1'b0}}, dma_read_data};
            end
        end
    end

endmodule

//--- logic/channel_register_file.sv
`timescale 1ns/1ps

module channel_register_file import dma_endpoint_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      write_valid,
    input  reg_write_t                write,
    input  logic [REG_ADDR_WIDTH-1:0] dma_read_address,
    input  logic [REG_ADDR_WIDTH-1:0] core_read_address,
    output logic [DATAPATH_WIDTH-1:0] dma_read_data,
    output logic [DATAPATH_WIDTH-1:0] core_read_data
);

    localparam int REGISTER_COUNT = CHANNEL_COUNT * REGISTER_FILE_DEPTH;

    // Flat storage, bank n starts at n times the bank depth
    logic [DATAPATH_WIDTH-1:0] registers [REGISTER_COUNT];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < REGISTER_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write_valid) begin
            registers[write.address] <= write.data;
        end
    end

    // Endpoint port
    assign dma_read_data = registers[dma_read_address];

    // Core port, no arbitration with the endpoint is needed
    assign core_read_data = registers[core_read_address];

endmodule

//--- logic/dma_subsystem_top.sv
`timescale 1ns/1ps

module dma_subsystem_top import dma_endpoint_pkg::*; #(
    parameter logic [31:0] BASE_ADDRESS = 32'h43c0_0000,
    parameter table_init_e TABLE_INIT = init_transparent,
    parameter int RAW_BUS_ACCESS = 1
)(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      bus_write,
    input  logic                      bus_read,
    input  logic [31:0]               bus_address,
    input  logic [31:0]               bus_write_data,
    output logic                      bus_read_valid,
    output logic [31:0]               bus_read_data,
    input  logic                      stream_write_valid,
    input  stream_write_t             stream_write,
    input  logic                      read_request_valid,
    input  stream_read_req_t          read_request,
    output logic                      read_request_ready,
    output logic                      read_response_valid,
    output logic [DATAPATH_WIDTH-1:0] read_response_data,
    input  logic                      table_write_valid,
    input  table_entry_t              table_write,
    input  logic [REG_ADDR_WIDTH-1:0] core_read_address,
    output logic [DATAPATH_WIDTH-1:0] core_read_data,
    output config_t                   active_config
);

    logic                      decoded_write_valid;
    bus_txn_t                  decoded_write_txn;
    logic                      decoded_read_valid;
    bus_txn_t                  decoded_read_txn;
    logic                      bus_response_valid;
    logic [31:0]               bus_response_data;
    logic [IO_ADDR_WIDTH-1:0]  write_lookup_address;
    logic [IO_ADDR_WIDTH-1:0]  read_lookup_address;
    logic [31:0]               write_lookup_entry;
    logic [31:0]               read_lookup_entry;
    logic                      reg_write_valid;
    reg_write_t                reg_write;
    logic [REG_ADDR_WIDTH-1:0] dma_read_address;
    logic [DATAPATH_WIDTH-1:0] dma_read_data;

    bus_register_decoder #(
        .BASE_ADDRESS(BASE_ADDRESS)
    ) bus_register_decoder_i (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write),
        .bus_read(bus_read),
        .bus_address(bus_address),
        .bus_write_data(bus_write_data),
        .response_valid(bus_response_valid),
        .response_data(bus_response_data),
        .write_valid(decoded_write_valid),
        .write_txn(decoded_write_txn),
        .read_valid(decoded_read_valid),
        .read_txn(decoded_read_txn),
        .bus_read_valid(bus_read_valid),
        .bus_read_data(bus_read_data)
    );

    io_translation_table #(
        .TABLE_INIT(TABLE_INIT)
    ) io_translation_table_i (
        .clock(clock),
        .reset(reset),
        .entry_write_valid(table_write_valid),
        .entry_write(table_write),
        .write_lookup_address(write_lookup_address),
        .read_lookup_address(read_lookup_address),
        .write_lookup_entry(write_lookup_entry),
        .read_lookup_entry(read_lookup_entry)
    );

    dma_endpoint #(
        .RAW_BUS_ACCESS(RAW_BUS_ACCESS)
    ) dma_endpoint_i (
        .clock(clock),
        .reset(reset),
        .stream_write_valid(stream_write_valid),
        .stream_write(stream_write),
        .bus_write_valid(decoded_write_valid),
        .bus_write_txn(decoded_write_txn),
        .bus_read_valid(decoded_read_valid),
        .bus_read_txn(decoded_read_txn),
        .read_request_valid(read_request_valid),
        .read_request(read_request),
        .write_lookup_entry(write_lookup_entry),
        .read_lookup_entry(read_lookup_entry),
        .dma_read_data(dma_read_data),
        .write_lookup_address(write_lookup_address),
        .read_lookup_address(read_lookup_address),
        .reg_write_valid(reg_write_valid),
        .reg_write(reg_write),
        .dma_read_address(dma_read_address),
        .read_request_ready(read_request_ready),
        .read_response_valid(read_response_valid),
        .read_response_data(read_response_data),
        .bus_response_valid(bus_response_valid),
        .bus_response_data(bus_response_data),
        .active_config(active_config)
    );

    channel_register_file channel_register_file_i (
        .clock(clock),
        .reset(reset),
        .write_valid(reg_write_valid),
        .write(reg_write),
        .dma_read_address(dma_read_address),
        .core_read_address(core_read_address),
        .dma_read_data(dma_read_data),
        .core_read_data(core_read_data)
    );

endmodule

//--- test/dma_endpoint_tb.sv
`timescale 1ns/1ps

module dma_endpoint_tb import dma_endpoint_pkg::*; ();

    localparam logic [31:0] BASE_ADDRESS = 32'h43c0_0000;
    localparam int CLOCK_PERIOD = 10;
    localparam int REGISTER_COUNT = CHANNEL_COUNT * REGISTER_FILE_DEPTH;
    localparam int STREAM_WRITE_COUNT = 300;
    localparam int STREAM_READ_COUNT = 120;
    localparam int CONFIG_ROUND_COUNT = 4;
    localparam int BUS_ACCESS_COUNT = 80;
    localparam int COLLISION_COUNT = 20;
    // Register sweeps, table writes and the accesses of every phase
    localparam int OPERATION_COUNT = 2 * REGISTER_COUNT + 2 * STREAM_WRITE_COUNT
        + 2 * STREAM_READ_COUNT + 3 * CONFIG_ROUND_COUNT + 4 * BUS_ACCESS_COUNT
        + 3 * COLLISION_COUNT + 4;
    localparam int TIMEOUT_CYCLES = OPERATION_COUNT * 2000 + 10000;
    localparam int WAIT_LIMIT = 20;

    logic clock;
    logic reset;
    logic bus_write;
    logic bus_read;
    logic [31:0] bus_address;
    logic [31:0] bus_write_data;
    logic bus_read_valid;
    logic [31:0] bus_read_data;
    logic stream_write_valid;
    stream_write_t stream_write;
    logic read_request_valid;
    stream_read_req_t read_request;
    logic read_request_ready;
    logic read_response_valid;
    logic [DATAPATH_WIDTH-1:0] read_response_data;
    logic table_write_valid;
    table_entry_t table_write;
    logic [REG_ADDR_WIDTH-1:0] core_read_address;
    logic [DATAPATH_WIDTH-1:0] core_read_data;
    config_t active_config;

    // Reference model state
    logic [31:0] table_model [REGISTER_FILE_DEPTH];
    logic [DATAPATH_WIDTH-1:0] register_model [REGISTER_COUNT];
    config_t config_model;
    integer seed = 51824;
    int check_count = 0;

    dma_subsystem_top #(
        .BASE_ADDRESS(BASE_ADDRESS),
        .TABLE_INIT(init_transparent),
        .RAW_BUS_ACCESS(0)
    ) dma_subsystem_top_i (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write),
        .bus_read(bus_read),
        .bus_address(bus_address),
        .bus_write_data(bus_write_data),
        .bus_read_valid(bus_read_valid),
        .bus_read_data(bus_read_data),
        .stream_write_valid(stream_write_valid),
        .stream_write(stream_write),
        .read_request_valid(read_request_valid),
        .read_request(read_request),
        .read_request_ready(read_request_ready),
        .read_response_valid(read_response_valid),
        .read_response_data(read_response_data),
        .table_write_valid(table_write_valid),
        .table_write(table_write),
        .core_read_address(core_read_address),
        .core_read_data(core_read_data),
        .active_config(active_config)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    initial begin
        #(longint'(TIMEOUT_CYCLES) * CLOCK_PERIOD);
        stop_with_error("Watchdog expired before the test sequence finished");
    end

    task automatic check_config(input string name, input config_t got, input config_t expected);
        check_count++;
        if (got !== expected) begin
            stop_with_error($sformatf("[FAIL] time %0t: %s is %h, expected %h",
                $time, name, got, expected));
        end
    endtask

    task automatic check_register(input string name, input logic [DATAPATH_WIDTH-1:0] got,
        input logic [DATAPATH_WIDTH-1:0] expected);
        check_count++;
        if (got !== expected) begin
            stop_with_error($sformatf("[FAIL] time %0t: %s is %h, expected %h",
                $time, name, got, expected));
        end
    endtask

    task automatic check_bus_data(input string name, input logic [31:0] got,
        input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            stop_with_error($sformatf("[FAIL] time %0t: %s is %h, expected %h",
                $time, name, got, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            stop_with_error($sformatf("[FAIL] time %0t: %s is %b, expected %b",
                $time, name, got, expected));
        end
    endtask

    // Bank base plus entry, wrapped to the size of the register file
    function automatic logic [REG_ADDR_WIDTH-1:0] model_address(input int channel,
        input logic [31:0] entry);
        return REG_ADDR_WIDTH'((channel * REGISTER_FILE_DEPTH + int'(entry)) % REGISTER_COUNT);
    endfunction

    // Register a stream write lands on, or would land on if unmapped writes were not dropped
    function automatic logic [REG_ADDR_WIDTH-1:0] stream_target(input int channel,
        input logic [5:0] io_address);
        return model_address(channel, table_model[io_address]);
    endfunction

    function automatic logic [31:0] random_entry();
        logic [31:0] r;
        r = $random(seed);
        // About one entry in four is left unmapped
        if (r[1:0] == 2'b00) begin
            return 32'b0;
        end
        return {26'b0, r[7:2]};
    endfunction

    function automatic logic [31:0] bus_byte_address(input logic [9:0] offset);
        return BASE_ADDRESS + 32'(offset) * 32'd4;
    endfunction

    function automatic void apply_stream_write(input int channel, input logic [5:0] io_address,
        input logic [DATAPATH_WIDTH-1:0] data);
        if (table_model[io_address] != 32'b0) begin
            register_model[model_address(channel, table_model[io_address])] = data;
        end
    endfunction

    task automatic read_core_register(input logic [REG_ADDR_WIDTH-1:0] address);
        @(posedge clock);
        core_read_address <= address;
        @(negedge clock);
        check_register($sformatf("core_read_data[%0d]", address), core_read_data,
            register_model[address]);
    endtask

    task automatic check_all_registers();
        for (int i = 0; i < REGISTER_COUNT; i++) begin
            read_core_register(REG_ADDR_WIDTH'(i));
        end
    endtask

    task automatic write_table(input logic [5:0] io_address, input logic [31:0] entry);
        @(posedge clock);
        table_write_valid <= 1'b1;
        table_write <= '{io_address: 16'(io_address), reg_index: entry};
        @(posedge clock);
        table_write_valid <= 1'b0;
        table_model[io_address] = entry;
    endtask

    task automatic write_stream(input logic [3:0] channel, input logic [5:0] io_address,
        input logic [DATAPATH_WIDTH-1:0] data);
        @(posedge clock);
        stream_write_valid <= 1'b1;
        stream_write <= '{channel: 16'(channel), io_address: 16'(io_address), data: data};
        @(posedge clock);
        stream_write_valid <= 1'b0;
        apply_stream_write(channel, io_address, data);
        read_core_register(stream_target(channel, io_address));
    endtask

    task automatic read_stream(input logic [3:0] channel, input logic [5:0] io_address);
        logic [DATAPATH_WIDTH-1:0] expected;
        int cycles;
        expected = register_model[model_address(channel, table_model[io_address])];
        @(posedge clock);
        read_request_valid <= 1'b1;
        read_request <= '{channel: 16'(channel), io_address: 16'(io_address)};
        cycles = 0;
        @(negedge clock);
        while (!read_request_ready) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("Stream read request was never accepted");
            end
            @(negedge clock);
        end
        // The request is taken at this edge
        @(posedge clock);
        read_request_valid <= 1'b0;
        cycles = 0;
        @(negedge clock);
        while (!read_response_valid) begin
            check_flag("read_request_ready", read_request_ready, 1'b0);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("Stream read response never arrived");
            end
            @(negedge clock);
        end
        if (cycles != 2) begin
            stop_with_error($sformatf("Stream read response came %0d cycles after acceptance, not 2",
                cycles));
        end
        check_register("read_response_data", read_response_data, expected);
        check_flag("read_request_ready", read_request_ready, 1'b1);
        @(negedge clock);
        check_flag("read_response_valid", read_response_valid, 1'b0);
    endtask

    task automatic write_bus(input logic [9:0] offset, input logic [31:0] data);
        @(posedge clock);
        bus_write <= 1'b1;
        bus_address <= bus_byte_address(offset);
        bus_write_data <= data;
        @(posedge clock);
        bus_write <= 1'b0;
        if (offset == 10'd0) begin
            config_model = config_t'(data);
        end else if (table_model[offset[5:0]] != 32'b0) begin
            register_model[model_address(0, table_model[offset[5:0]])] = data[DATAPATH_WIDTH-1:0];
        end
        // Decoder stage, then endpoint stage, then the register file
        repeat (2) @(posedge clock);
    endtask

    task automatic read_bus(input logic [9:0] offset);
        logic [31:0] expected;
        int cycles;
        if (offset == 10'd0) begin
            expected = config_model;
        end else begin
            expected = 32'(register_model[model_address(0, table_model[offset[5:0]])]);
        end
        @(posedge clock);
        bus_read <= 1'b1;
        bus_address <= bus_byte_address(offset);
        @(posedge clock);
        bus_read <= 1'b0;
        cycles = 0;
        @(negedge clock);
        while (!bus_read_valid) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("Bus read response never arrived");
            end
            @(negedge clock);
        end
        if (cycles != 1) begin
            stop_with_error($sformatf("Bus read response came %0d cycles after decoding, not 1",
                cycles));
        end
        check_bus_data("bus_read_data", bus_read_data, expected);
        @(negedge clock);
        check_flag("bus_read_valid", bus_read_valid, 1'b0);
    endtask

    task automatic write_bus_with_stream(input logic [5:0] offset, input logic [31:0] bus_data,
        input logic [3:0] channel, input logic [5:0] io_address,
        input logic [DATAPATH_WIDTH-1:0] data);
        @(posedge clock);
        bus_write <= 1'b1;
        bus_address <= bus_byte_address(10'(offset));
        bus_write_data <= bus_data;
        // The decoder delays the bus write by one cycle, so both meet at the endpoint
        @(posedge clock);
        bus_write <= 1'b0;
        stream_write_valid <= 1'b1;
        stream_write <= '{channel: 16'(channel), io_address: 16'(io_address), data: data};
        @(posedge clock);
        stream_write_valid <= 1'b0;
        apply_stream_write(channel, io_address, data);
        read_core_register(stream_target(channel, io_address));
        read_core_register(model_address(0, table_model[offset]));
    endtask

    initial begin
        logic [31:0] r;
        logic [5:0] offset;
        reset = 1'b0;
        bus_write = 1'b0;
        bus_read = 1'b0;
        bus_address = 32'b0;
        bus_write_data = 32'b0;
        stream_write_valid = 1'b0;
        stream_write = '0;
        read_request_valid = 1'b0;
        read_request = '0;
        table_write_valid = 1'b0;
        table_write = '0;
        core_read_address = '0;
        for (int i = 0; i < REGISTER_FILE_DEPTH; i++) begin
            table_model[i] = 32'(i);
        end
        for (int i = 0; i < REGISTER_COUNT; i++) begin
            register_model[i] = '0;
        end
        config_model = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b1;

        // State right after reset
        @(negedge clock);
        check_flag("read_request_ready", read_request_ready, 1'b1);
        check_config("active_config", active_config, config_model);
        check_all_registers();
        r = $random(seed);
        read_stream(r[3:0], 6'd1 + 6'(r[9:4] % 63));

        // Stream writes with an occasional table update
        for (int i = 0; i < STREAM_WRITE_COUNT; i++) begin
            if (i % 8 == 0) begin
                r = $random(seed);
                write_table(r[5:0], random_entry());
            end
            r = $random(seed);
            write_stream(r[3:0], r[9:4], r[31:12]);
        end

        for (int i = 0; i < STREAM_READ_COUNT; i++) begin
            r = $random(seed);
            write_table(r[5:0], random_entry());
            r = $random(seed);
            read_stream(r[3:0], r[9:4]);
        end

        // Configuration word through the bus at offset zero
        for (int i = 0; i < CONFIG_ROUND_COUNT; i++) begin
            r = $random(seed);
            write_bus(10'd0, r);
            @(negedge clock);
            check_config("active_config", active_config, config_model);
            read_bus(10'd0);
        end

        for (int i = 0; i < BUS_ACCESS_COUNT; i++) begin
            r = $random(seed);
            offset = 6'd1 + 6'(r[7:0] % 63);
            if (i % 4 == 0) begin
                write_table(offset, random_entry());
            end
            r = $random(seed);
            write_bus(10'(offset), r);
            read_core_register(model_address(0, table_model[offset]));
            read_bus(10'(offset));
        end

        for (int i = 0; i < COLLISION_COUNT; i++) begin
            r = $random(seed);
            offset = 6'd1 + 6'(r[7:0] % 63);
            r = $random(seed);
            write_bus_with_stream(offset, $random(seed), r[3:0], r[9:4], r[31:12]);
        end

        check_all_registers();

        if (check_count > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_error("No checks were performed");
        end
    end

endmodule

//--- verilog.f
logic/dma_endpoint_pkg.sv
logic/bus_register_decoder.sv
logic/io_translation_table.sv
logic/dma_endpoint.sv
logic/channel_register_file.sv
logic/dma_subsystem_top.sv
test/dma_endpoint_tb.sv

//--- Bender.yml
package:
  name: dma_endpoint

sources:
  - logic/dma_endpoint_pkg.sv
  - logic/bus_register_decoder.sv
  - logic/io_translation_table.sv
  - logic/dma_endpoint.sv
  - logic/channel_register_file.sv
  - logic/dma_subsystem_top.sv
  - target: test
    files:
      - test/dma_endpoint_tb.sv
